// File: logic/gfx_macros.svh
`ifndef GFX_MACROS_SVH
`define GFX_MACROS_SVH

// Frame geometry shared by every block of the fill engine.
`define GFX_FB_WIDTH 16
`define GFX_FB_HEIGHT 12
`define GFX_PIXEL_BITS 12

// Coordinate widths follow from the frame size.
`define GFX_X_BITS ($clog2(`GFX_FB_WIDTH))
`define GFX_Y_BITS ($clog2(`GFX_FB_HEIGHT))

// Linear pixel address into the frame buffer.
`define GFX_FB_DEPTH (`GFX_FB_WIDTH * `GFX_FB_HEIGHT)
`define GFX_ADDR_BITS ($clog2(`GFX_FB_DEPTH))

// A command payload is wide enough to hold two corners.
`define GFX_PAYLOAD_BITS (2 * `GFX_X_BITS + 2 * `GFX_Y_BITS)

`endif

// File: logic/gfx_pkg.sv
`include "gfx_macros.svh"

package gfx_pkg;

  typedef enum logic {
    GFX_OP_CLEAR = 1'b0,
    GFX_OP_RECT  = 1'b1
  } gfx_op_e;

  // Inclusive corners of an axis-aligned rectangle.
  typedef struct packed {
    logic [`GFX_X_BITS-1:0] x0;
    logic [`GFX_Y_BITS-1:0] y0;
    logic [`GFX_X_BITS-1:0] x1;
    logic [`GFX_Y_BITS-1:0] y1;
  } gfx_rect_t;

  // A clear carries its color in the low bits of the payload.
  typedef struct packed {
    logic [`GFX_PAYLOAD_BITS-`GFX_PIXEL_BITS-1:0] pad;
    logic [`GFX_PIXEL_BITS-1:0]                   color;
  } gfx_clear_t;

  typedef union packed {
    gfx_clear_t clear;
    gfx_rect_t  rect;
  } gfx_payload_u;

  // A clear takes its color from payload.clear.color.
  // A rect takes its color from the color field and its corners from payload.rect.
  typedef struct packed {
    gfx_op_e                    op;
    logic [`GFX_PIXEL_BITS-1:0] color;
    gfx_payload_u               payload;
  } gfx_cmd_t;

  typedef struct packed {
    logic [`GFX_X_BITS-1:0]     x;
    logic [`GFX_Y_BITS-1:0]     y;
    logic [`GFX_PIXEL_BITS-1:0] color;
    logic                       valid;
    logic                       last;
  } gfx_pixel_t;

endpackage

// File: logic/gfx_cmd_fsm.sv
`include "gfx_macros.svh"

module gfx_cmd_fsm (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       cmd_valid,
  input  gfx_pkg::gfx_cmd_t          cmd,
  input  logic                       wr_last,
  input  logic                       empty,
  output logic                       start,
  output gfx_pkg::gfx_rect_t         region,
  output logic [`GFX_PIXEL_BITS-1:0] fill_color,
  output logic                       busy,
  output logic                       done
);
  import gfx_pkg::*;

  typedef logic [`GFX_X_BITS-1:0] coord_x_t;
  typedef logic [`GFX_Y_BITS-1:0] coord_y_t;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_LAUNCH,
    ST_FILL,
    ST_FINISH
  } state_e;

  state_e   state;
  state_e   next_state;
  gfx_cmd_t cmd_q;
  logic     accept;

  // The done cycle already counts as not busy, so a new command may land there.
  assign accept = cmd_valid && !busy;

  always_comb begin
    next_state = state;
    case (state)
      ST_IDLE, ST_FINISH: begin
        next_state = accept ? ST_LAUNCH : ST_IDLE;
      end
      ST_LAUNCH: begin
        next_state = ST_FILL;
      end
      ST_FILL: begin
        if (wr_last || empty) begin
          next_state = ST_FINISH;
        end
      end
      default: begin
        next_state = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ST_IDLE;
    end else begin
      state <= next_state;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      cmd_q <= cmd;
    end
  end

  assign start = (state == ST_LAUNCH);
  assign busy  = (state == ST_LAUNCH) || (state == ST_FILL);
  assign done  = (state == ST_FINISH);

  // The opcode selects which view of the payload word is meaningful.
  always_comb begin
    if (cmd_q.op == GFX_OP_CLEAR) begin
      region.x0  = '0;
      region.y0  = '0;
      region.x1  = coord_x_t'(`GFX_FB_WIDTH - 1);
      region.y1  = coord_y_t'(`GFX_FB_HEIGHT - 1);
      fill_color = cmd_q.payload.clear.color;
    end else begin
      region     = cmd_q.payload.rect;
      fill_color = cmd_q.color;
    end
  end

endmodule

// File: logic/gfx_raster_counter.sv
`include "gfx_macros.svh"

module gfx_raster_counter (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   load,
  input  gfx_pkg::gfx_rect_t     bounds,
  input  logic                   inc,
  output logic [`GFX_X_BITS-1:0] x,
  output logic [`GFX_Y_BITS-1:0] y,
  output logic                   at_last
);
  import gfx_pkg::*;

  gfx_rect_t bounds_q;
  logic      at_row_end;

  assign at_row_end = (x == bounds_q.x1);
  assign at_last    = at_row_end && (y == bounds_q.y1);

  always_ff @(posedge clk) begin
    if (reset) begin
      bounds_q <= '0;
    end else if (load) begin
      bounds_q <= bounds;
    end
  end

  // Scan runs left to right, then top to bottom, and parks on the final corner.
  always_ff @(posedge clk) begin
    if (reset) begin
      x <= '0;
      y <= '0;
    end else if (load) begin
      x <= bounds.x0;
      y <= bounds.y0;
    end else if (inc && !at_last) begin
      if (at_row_end) begin
        x <= bounds_q.x0;
        y <= y + 1'b1;
      end else begin
        x <= x + 1'b1;
      end
    end
  end

endmodule

// File: logic/gfx_fill_source.sv
`include "gfx_macros.svh"

module gfx_fill_source (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       start,
  input  gfx_pkg::gfx_rect_t         region,
  input  logic [`GFX_PIXEL_BITS-1:0] fill_color,
  input  logic [`GFX_X_BITS-1:0]     x,
  input  logic [`GFX_Y_BITS-1:0]     y,
  input  logic                       at_last,
  output logic                       load,
  output gfx_pkg::gfx_rect_t         bounds,
  output logic                       inc,
  output logic                       empty,
  output gfx_pkg::gfx_pixel_t        wr_pixel
);
  import gfx_pkg::*;

  typedef logic [`GFX_X_BITS-1:0] coord_x_t;
  typedef logic [`GFX_Y_BITS-1:0] coord_y_t;

  localparam coord_x_t MAX_X = coord_x_t'(`GFX_FB_WIDTH - 1);
  localparam coord_y_t MAX_Y = coord_y_t'(`GFX_FB_HEIGHT - 1);

  gfx_rect_t                  clipped;
  logic                       clip_empty;
  logic                       active;
  logic [`GFX_PIXEL_BITS-1:0] color_q;

  // Each corner is clamped on its own, so a region wholly off one edge
  // collapses onto the border row or column.
  always_comb begin
    clipped.x0 = (region.x0 > MAX_X) ? MAX_X : region.x0;
    clipped.x1 = (region.x1 > MAX_X) ? MAX_X : region.x1;
    clipped.y0 = (region.y0 > MAX_Y) ? MAX_Y : region.y0;
    clipped.y1 = (region.y1 > MAX_Y) ? MAX_Y : region.y1;
  end

  assign clip_empty = (clipped.x0 > clipped.x1) || (clipped.y0 > clipped.y1);
  assign bounds     = clipped;
  assign load       = start && !clip_empty;
  assign inc        = active;

  always_ff @(posedge clk) begin
    if (reset) begin
      empty <= 1'b0;
    end else begin
      empty <= start && clip_empty;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      active <= 1'b0;
    end else if (load) begin
      active <= 1'b1;
    end else if (active && at_last) begin
      active <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      color_q <= fill_color;
    end
  end

  // One registered write per active cycle, one cycle behind the counter.
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_pixel.valid <= 1'b0;
      wr_pixel.last  <= 1'b0;
    end else begin
      wr_pixel.x     <= x;
      wr_pixel.y     <= y;
      wr_pixel.color <= color_q;
      wr_pixel.valid <= active;
      wr_pixel.last  <= active && at_last;
    end
  end

endmodule

// File: logic/gfx_framebuffer.sv
`include "gfx_macros.svh"

module gfx_framebuffer (
  input  logic                       clk,
  input  gfx_pkg::gfx_pixel_t        wr_pixel,
  input  logic [`GFX_ADDR_BITS-1:0]  rd_addr,
  output logic [`GFX_PIXEL_BITS-1:0] rd_data
);
  typedef logic [`GFX_ADDR_BITS-1:0] addr_t;

  logic [`GFX_PIXEL_BITS-1:0] mem [`GFX_FB_DEPTH];
  addr_t                      wr_addr;

  // Row-major layout, so the address is y times the frame width plus x.
  assign wr_addr = addr_t'(wr_pixel.y) * addr_t'(`GFX_FB_WIDTH) + addr_t'(wr_pixel.x);

  always_ff @(posedge clk) begin
    if (wr_pixel.valid) begin
      mem[wr_addr] <= wr_pixel.color;
    end
  end

  // Read data lands one cycle after the address.
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];
  end

endmodule

// File: logic/gfx_engine.sv
`include "gfx_macros.svh"

module gfx_engine (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       cmd_valid,
  input  gfx_pkg::gfx_cmd_t          cmd,
  input  logic [`GFX_ADDR_BITS-1:0]  rd_addr,
  output logic                       busy,
  output logic                       done,
  output logic [`GFX_PIXEL_BITS-1:0] rd_data
);
  import gfx_pkg::*;

  logic                       start;
  gfx_rect_t                  region;
  logic [`GFX_PIXEL_BITS-1:0] fill_color;
  logic                       empty;
  logic                       load;
  gfx_rect_t                  bounds;
  logic                       inc;
  logic [`GFX_X_BITS-1:0]     cnt_x;
  logic [`GFX_Y_BITS-1:0]     cnt_y;
  logic                       at_last;
  gfx_pixel_t                 wr_pixel;

  gfx_cmd_fsm u_cmd_fsm (
    .clk        (clk),
    .reset      (reset),
    .cmd_valid  (cmd_valid),
    .cmd        (cmd),
    .wr_last    (wr_pixel.valid && wr_pixel.last),
    .empty      (empty),
    .start      (start),
    .region     (region),
    .fill_color (fill_color),
    .busy       (busy),
    .done       (done)
  );

  gfx_raster_counter u_raster_counter (
    .clk     (clk),
    .reset   (reset),
    .load    (load),
    .bounds  (bounds),
    .inc     (inc),
    .x       (cnt_x),
    .y       (cnt_y),
    .at_last (at_last)
  );

  gfx_fill_source u_fill_source (
    .clk        (clk),
    .reset      (reset),
    .start      (start),
    .region     (region),
    .fill_color (fill_color),
    .x          (cnt_x),
    .y          (cnt_y),
    .at_last    (at_last),
    .load       (load),
    .bounds     (bounds),
    .inc        (inc),
    .empty      (empty),
    .wr_pixel   (wr_pixel)
  );

  gfx_framebuffer u_framebuffer (
    .clk      (clk),
    .wr_pixel (wr_pixel),
    .rd_addr  (rd_addr),
    .rd_data  (rd_data)
  );

endmodule

// File: dv/gfx_clock_gen.sv
module gfx_clock_gen (
  output logic clk
);
  timeunit 1ns;
  timeprecision 1ps;

  // A 10 ns half period gives the 20 ns clock.
  initial begin
    clk = 1'b0;
    forever begin
      #10 clk = ~clk;
    end
  end

endmodule

// File: dv/gfx_engine_assertions.sv
`include "gfx_macros.svh"

module gfx_engine_assertions (
  input logic                clk,
  input logic                reset,
  input logic                busy,
  input logic                done,
  input gfx_pkg::gfx_pixel_t wr_pixel
);
  timeunit 1ns;
  timeprecision 1ps;

  int failures = 0;

  // Done marks the end of one command and never lasts longer than a cycle.
  done_single_cycle: assert property (@(posedge clk) disable iff (reset) done |=> !done)
    else begin
      $error("done stayed high for more than one cycle");
      failures++;
    end

  // Writes only happen while a command is being worked on.
  valid_while_busy: assert property (@(posedge clk) disable iff (reset)
    wr_pixel.valid |-> busy)
    else begin
      $error("pixel write while the engine is not busy");
      failures++;
    end

  write_in_frame: assert property (@(posedge clk) disable iff (reset)
    wr_pixel.valid |-> (int'(wr_pixel.x) < `GFX_FB_WIDTH) && (int'(wr_pixel.y) < `GFX_FB_HEIGHT))
    else begin
      $error("pixel write outside the frame");
      failures++;
    end

endmodule

bind gfx_engine gfx_engine_assertions u_assertions (
  .clk      (clk),
  .reset    (reset),
  .busy     (busy),
  .done     (done),
  .wr_pixel (wr_pixel)
);

// File: dv/gfx_engine_tb.sv
`include "gfx_macros.svh"

module gfx_engine_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import gfx_pkg::*;

  typedef logic [`GFX_X_BITS-1:0]     coord_x_t;
  typedef logic [`GFX_Y_BITS-1:0]     coord_y_t;
  typedef logic [`GFX_PIXEL_BITS-1:0] color_t;
  typedef logic [`GFX_ADDR_BITS-1:0]  addr_t;

  localparam int DONE_LIMIT    = 400;
  localparam int COMPARE_LIMIT = 1000;
  localparam int IDLE_LIMIT    = 4000;
  localparam int X_MASK        = (1 << `GFX_X_BITS) - 1;
  localparam int Y_MASK        = (1 << `GFX_Y_BITS) - 1;
  localparam int COLOR_MASK    = (1 << `GFX_PIXEL_BITS) - 1;

  logic     clk;
  logic     reset;
  logic     cmd_valid;
  gfx_cmd_t cmd;
  addr_t    rd_addr;
  logic     busy;
  logic     done;
  color_t   rd_data;

  // Expected frame contents, updated by the reference model.
  color_t frame_model [`GFX_FB_DEPTH];
  int     seed = 50;
  int     cmp_requests = 0;
  int     cmp_completed = 0;

  gfx_clock_gen u_clock_gen (
    .clk (clk)
  );

  gfx_engine dut (
    .clk       (clk),
    .reset     (reset),
    .cmd_valid (cmd_valid),
    .cmd       (cmd),
    .rd_addr   (rd_addr),
    .busy      (busy),
    .done      (done),
    .rd_data   (rd_data)
  );

  task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("Fail at %0d ns: %s is 0x%0h, expected 0x%0h", $time, what, actual, expected);
      $display("=== FAIL ===");
      $fatal(1, "Mismatch on %s", what);
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timed out at %0d ns while waiting for %s", $time, what);
    $display("=== FAIL ===");
    $fatal(1, "Timeout waiting for %s", what);
  endtask

  function automatic int clamp_coord(input int v, input int max_v);
    return (v > max_v) ? max_v : v;
  endfunction

  // The command's own color field is filled with a different value to show it is unused.
  function automatic gfx_cmd_t make_clear(input int color, input int unused_color);
    gfx_cmd_t c;
    c.op                  = GFX_OP_CLEAR;
    c.color               = color_t'(unused_color);
    c.payload.clear.pad   = '0;
    c.payload.clear.color = color_t'(color);
    return c;
  endfunction

  function automatic gfx_cmd_t make_rect(input int x0, input int y0, input int x1, input int y1,
                                         input int color);
    gfx_cmd_t c;
    c.op              = GFX_OP_RECT;
    c.color           = color_t'(color);
    c.payload.rect.x0 = coord_x_t'(x0);
    c.payload.rect.y0 = coord_y_t'(y0);
    c.payload.rect.x1 = coord_x_t'(x1);
    c.payload.rect.y1 = coord_y_t'(y1);
    return c;
  endfunction

  // Reference model. Clamps each corner, paints the inclusive region, returns the pixel count.
  function automatic int apply_cmd(input gfx_cmd_t c);
    int     x0;
    int     y0;
    int     x1;
    int     y1;
    int     count;
    color_t col;
    count = 0;
    if (c.op == GFX_OP_CLEAR) begin
      x0  = 0;
      y0  = 0;
      x1  = `GFX_FB_WIDTH - 1;
      y1  = `GFX_FB_HEIGHT - 1;
      col = c.payload.clear.color;
    end else begin
      x0  = clamp_coord(int'(c.payload.rect.x0), `GFX_FB_WIDTH - 1);
      y0  = clamp_coord(int'(c.payload.rect.y0), `GFX_FB_HEIGHT - 1);
      x1  = clamp_coord(int'(c.payload.rect.x1), `GFX_FB_WIDTH - 1);
      y1  = clamp_coord(int'(c.payload.rect.y1), `GFX_FB_HEIGHT - 1);
      col = c.color;
    end
    for (int y = y0; y <= y1; y++) begin
      for (int x = x0; x <= x1; x++) begin
        frame_model[addr_t'(y * `GFX_FB_WIDTH + x)] = col;
        count++;
      end
    end
    return count;
  endfunction

  task automatic issue_cmd(input gfx_cmd_t c);
    @(negedge clk);
    cmd       = c;
    cmd_valid = 1'b1;
    @(negedge clk);
    cmd_valid = 1'b0;
    check_equal(busy, 1'b1, "busy after accept");
  endtask

  task automatic strobe_while_busy(input gfx_cmd_t c);
    @(negedge clk);
    check_equal(busy, 1'b1, "busy at extra strobe");
    cmd       = c;
    cmd_valid = 1'b1;
    @(negedge clk);
    cmd_valid = 1'b0;
  endtask

  task automatic wait_done(output int cycles);
    cycles = 0;
    while (!done) begin
      @(negedge clk);
      cycles++;
      if (cycles > DONE_LIMIT) begin
        report_timeout("the done pulse");
      end
    end
  endtask

  task automatic compare_frame();
    int waited;
    waited = 0;
    cmp_requests++;
    while (cmp_completed != cmp_requests) begin
      @(posedge clk);
      waited++;
      if (waited > COMPARE_LIMIT) begin
        report_timeout("the frame readback");
      end
    end
  endtask

  // Done follows the start pulse after the written pixel count plus two cycles.
  task automatic finish_cmd(input int expected_cycles, input int strobe_cycles);
    int cycles;
    wait_done(cycles);
    check_equal(cycles + strobe_cycles, expected_cycles, "cycles from start to done");
    check_equal(busy, 1'b0, "busy at done");
    compare_frame();
  endtask

  task automatic run_cmd(input gfx_cmd_t c);
    int written;
    issue_cmd(c);
    written = apply_cmd(c);
    finish_cmd(written + 2, 0);
  endtask

  // Reads back every address and checks it against the model.
  initial begin
    int idle;
    rd_addr = '0;
    forever begin
      idle = 0;
      while (cmp_completed == cmp_requests) begin
        @(posedge clk);
        idle++;
        if (idle > IDLE_LIMIT) begin
          report_timeout("a frame compare request");
        end
      end
      for (int a = 0; a < `GFX_FB_DEPTH; a++) begin
        @(negedge clk);
        if (a > 0) begin
          check_equal(rd_data, frame_model[addr_t'(a - 1)], $sformatf("pixel %0d", a - 1));
        end
        rd_addr = addr_t'(a);
      end
      @(negedge clk);
      check_equal(rd_data, frame_model[addr_t'(`GFX_FB_DEPTH - 1)],
                  $sformatf("pixel %0d", `GFX_FB_DEPTH - 1));
      check_equal(dut.u_assertions.failures, 0, "assertion failure count");
      cmp_completed++;
    end
  end

  initial begin
    int rnd;
    int written;
    reset     = 1'b1;
    cmd_valid = 1'b0;
    cmd       = '0;
    for (int i = 0; i < 5; i++) begin
      @(negedge clk);
    end
    reset = 1'b0;
    check_equal(busy, 1'b0, "busy after reset");
    check_equal(done, 1'b0, "done after reset");

    rnd = $random(seed);
    run_cmd(make_clear(rnd & COLOR_MASK, (rnd >> 12) & COLOR_MASK));
    run_cmd(make_rect(3, 2, 9, 7, 'h5a3));

    // Rectangles that reach past the bottom edge get clamped.
    run_cmd(make_rect(10, 7, 15, 14, 'h0f0));
    run_cmd(make_rect(0, 13, 5, 15, 'h00f));
    run_cmd(make_rect(9, 3, 4, 8, 'hf00));

    // A second command during the fill must leave no trace.
    issue_cmd(make_rect(2, 1, 7, 4, 'h3c3));
    written = apply_cmd(make_rect(2, 1, 7, 4, 'h3c3));
    strobe_while_busy(make_clear('hfff, 'h000));
    finish_cmd(written + 2, 2);

    for (int i = 0; i < 20; i++) begin
      rnd = $random(seed);
      if (rnd[0]) begin
        run_cmd(make_rect((rnd >> 1) & X_MASK, (rnd >> 5) & Y_MASK, (rnd >> 9) & X_MASK,
                          (rnd >> 13) & Y_MASK, (rnd >> 17) & COLOR_MASK));
      end else begin
        run_cmd(make_clear((rnd >> 1) & COLOR_MASK, (rnd >> 13) & COLOR_MASK));
      end
    end

    if (dut.u_assertions.failures == 0) begin
      $display("=== PASS ===");
      $finish;
    end else begin
      $display("Concurrent assertions failed %0d times", dut.u_assertions.failures);
      $display("=== FAIL ===");
      $fatal(1, "Assertion failures");
    end
  end

endmodule

// File: files.f
+incdir+logic
logic/gfx_pkg.sv
logic/gfx_cmd_fsm.sv
logic/gfx_raster_counter.sv
logic/gfx_fill_source.sv
logic/gfx_framebuffer.sv
logic/gfx_engine.sv
dv/gfx_clock_gen.sv
dv/gfx_engine_assertions.sv
dv/gfx_engine_tb.sv

// File: run.sh
#!/bin/sh
# Builds the fill engine testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module gfx_engine_tb \
  -f files.f -o gfx_engine_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/gfx_engine_sim +verilator+error+limit+100 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^=== PASS ===$" sim.log; then
  exit 0
fi
echo "Pass message not found in sim.log"
exit 1
